// File: compile.f
logic/vdp_pkg.sv
logic/vram_cpu_if.sv
logic/vdp_port_ctrl.sv
logic/vdp_vram.sv
logic/vdp_scan_timing.sv
logic/vdp_bitmap_fetch.sv
logic/vdp_palette.sv
logic/vdp_top.sv
verif/vdp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the VDP testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module vdp_tb -o vdp_sim \
    && ./obj_dir/vdp_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verif/vdp_tb.sv
// VDP testbench: drives the CPU I/O ports and checks VRAM, decode, display, timing and interrupt
`timescale 1ns/1ns
`default_nettype none

module vdp_tb;
    import vdp_pkg::*;

    localparam int CLK_NS = 40;
    localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);

    logic        cpu_bus, rst_n, iorq, m1, req, wr, interrupt;
    logic        hs, vs, de, hblank, vblank;
    logic [7:0]  addr, data_in, data_out, r, g, b, rd_val;
    logic [15:0] lfsr = 16'd9828;
    logic [7:0]  vmem [4096];
    logic [2:0]  pal_r [16], pal_g [16], pal_b [16];
    logic [3:0]  backdrop_m = '0;
    logic        disp_on = 1'b0;
    logic        disp_chk = 1'b0, tim_chk = 1'b0, irq_off = 1'b0, de_q = 1'b0;
    logic        vblank_q = 1'b0;
    int          de_len = 0, hs_len = 0, hb_len = 0, vs_len = 0, de_lines = 0;
    int          errors = 0, err_start = 0, passed = 0, failed = 0;
    string       cur_test = "reset";
    logic [23:0] exp_rgb;
    longint      t1, t2;

    vdp_top vdp_top_i (.*);

    initial begin
        cpu_bus = 1'b0;
        forever #(CLK_NS / 2) cpu_bus = ~cpu_bus;
    end

    // Ends a run that stalls somewhere, twelve frames covers every test
    initial begin
        #(longint'(12) * FRAME_CYCLES * CLK_NS);
        $display("Watchdog: the run did not finish within 12 frames");
        $display("sim failed");
        $finish;
    end

    // Taps 16, 14, 13 and 11, one step per bit taken
    function automatic logic [15:0] lfsr_take(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    // A 3-bit level repeated across the 8-bit output
    function automatic logic [7:0] expand_level(input logic [2:0] c);
        logic [7:0] w;
        w = {5'd0, c};
        return (w << 5) | (w << 2) | (w >> 1);
    endfunction

    function automatic logic [23:0] entry_rgb(input logic [3:0] i);
        return {expand_level(pal_r[i]), expand_level(pal_g[i]), expand_level(pal_b[i])};
    endfunction

    // Output pixel position comes from de runs, frames restart on vblank
    always_ff @(posedge cpu_bus) begin
        de_q     <= de;
        vblank_q <= vblank;
        de_len   <= de ? de_len + 1 : 0;
        hs_len   <= hs ? hs_len + 1 : 0;
        hb_len   <= hblank ? hb_len + 1 : 0;
        vs_len   <= vs ? vs_len + 1 : 0;
        if (vblank)
            de_lines <= 0;
        else if (!de && de_q)
            de_lines <= de_lines + 1;
    end

    always_comb begin
        logic [7:0] byte_v;
        byte_v = vmem[de_lines * int'(BYTES_PER_LINE) + de_len / 2];
        if (de && disp_on)
            exp_rgb = entry_rgb(de_len[0] ? byte_v[3:0] : byte_v[7:4]);
        else
            exp_rgb = entry_rgb(backdrop_m);
    end

    a_rgb: assert property (@(posedge cpu_bus) disp_chk |-> {r, g, b} == exp_rgb)
        else begin
            errors++;
            $display("Error %s: expected %h, actual %h", cur_test, exp_rgb, {r, g, b});
        end

    a_de_len: assert property (@(posedge cpu_bus) tim_chk && $fell(de) |-> de_len == 32)
        else begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", cur_test, 32, de_len);
        end

    a_hs_len: assert property (@(posedge cpu_bus) tim_chk && $fell(hs) |-> hs_len == 6)
        else begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", cur_test, 6, hs_len);
        end

    // Horizontal blanking fills the rest of each 64-cycle line
    a_hb_len: assert property (@(posedge cpu_bus)
        tim_chk && $fell(hblank) |-> hb_len == 32)
        else begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", cur_test, 32, hb_len);
        end

    // Vertical sync covers two whole lines
    a_vs_len: assert property (@(posedge cpu_bus) tim_chk && $fell(vs) |-> vs_len == 128)
        else begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", cur_test, 128, vs_len);
        end

    a_lines: assert property (@(posedge cpu_bus) tim_chk && $rose(vblank) |-> de_lines == 24)
        else begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", cur_test, 24, de_lines);
        end

    a_irq_off: assert property (@(posedge cpu_bus) irq_off |-> !interrupt)
        else begin
            errors++;
            $display("Error %s: expected %0d, actual %0d", cur_test, 0, interrupt);
        end

    task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act)
        else begin
            errors++;
            $display("Error %s: expected %h, actual %h", cur_test, exp, act);
        end
    endtask

    task automatic close_test();
        if (errors == err_start) begin
            passed++;
            $display("%s: ok", cur_test);
        end else begin
            failed++;
            $display("%s: %0d errors", cur_test, errors - err_start);
        end
        err_start = errors;
    endtask

    // One bus cycle, then three idle cycles so a VRAM request can finish
    task automatic io_access(input logic [7:0] port, input logic w, input logic [7:0] d,
                             input logic m1_v, output logic [7:0] q);
        @(posedge cpu_bus);
        #2;
        {iorq, req, wr, m1, addr, data_in} = {1'b1, 1'b1, w, m1_v, port, d};
        #18 q = data_out;
        @(posedge cpu_bus);
        #2;
        {iorq, req, wr, m1} = 4'b0000;
        repeat (2) @(posedge cpu_bus);
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] d);
        logic [7:0] q;
        io_access(port, 1'b1, d, 1'b0, q);
    endtask

    task automatic io_read(input logic [7:0] port, output logic [7:0] q);
        io_access(port, 1'b0, 8'h00, 1'b0, q);
    endtask

    task automatic write_reg(input logic [4:0] num, input logic [7:0] val);
        io_write(8'h99, val);
        io_write(8'h99, {3'b100, num});
    endtask

    task automatic set_write_addr(input logic [11:0] a);
        io_write(8'h99, a[7:0]);
        io_write(8'h99, {4'b0100, a[11:8]});
    endtask

    task automatic set_read_addr(input logic [11:0] a);
        io_write(8'h99, a[7:0]);
        io_write(8'h99, {4'b0000, a[11:8]});
    endtask

    // Stores at the model address and steps it, like the VDP pointer
    task automatic vram_store(inout logic [11:0] a, input logic [7:0] d);
        io_write(8'h98, d);
        vmem[a] = d;
        a = a + 1'b1;
    endtask

    task automatic load_palette();
        logic [8:0]  c;
        logic [15:0] rnd;
        write_reg(5'd16, 8'h00);
        for (int i = 0; i < 16; i++) begin
            rnd = lfsr_take(9);
            c = rnd[8:0];
            io_write(8'h9A, {1'b0, c[8:6], 1'b0, c[2:0]});
            io_write(8'h9A, {5'd0, c[5:3]});
            {pal_r[i], pal_g[i], pal_b[i]} = c;
        end
    endtask

    // Waits for the start of vertical blanking at the outputs
    task automatic wait_frame();
        int n;
        n = 0;
        do begin
            @(posedge cpu_bus);
            n++;
        end while (!(vblank && !vblank_q) && n < 2 * FRAME_CYCLES);
        if (!(vblank && !vblank_q)) begin
            errors++;
            $display("%s: vertical blanking did not start within two frames", cur_test);
        end
    endtask

    task automatic wait_irq(output longint t);
        int n;
        n = 0;
        while (!interrupt && n < 2 * FRAME_CYCLES) begin
            @(posedge cpu_bus);
            n++;
        end
        t = $time;
        if (!interrupt) begin
            errors++;
            $display("%s: interrupt did not rise within two frames", cur_test);
        end
    endtask

    initial begin
        logic [11:0] a;
        logic [15:0] rnd;
        {rst_n, iorq, m1, req, wr} = 5'b00000;
        addr = 8'h00;
        data_in = 8'h00;
        for (int i = 0; i < 4096; i++)
            vmem[i] = 8'h00;
        for (int i = 0; i < 16; i++)
            {pal_r[i], pal_g[i], pal_b[i]} = 9'd0;
        repeat (15) @(posedge cpu_bus);
        #20;
        check_value(32'h0, {29'd0, interrupt, hs, vs});
        check_value(32'hFF, 32'(data_out));
        @(posedge cpu_bus);
        #2 rst_n = 1'b1;
        #18;
        check_value(32'h0, {29'd0, interrupt, hs, vs});
        check_value(32'hFF, 32'(data_out));
        tim_chk = 1'b1;
        close_test();

        // Read-back starts with a prefetch, each data read refills it
        cur_test = "vram_rw";
        a = 12'h800;
        set_write_addr(a);
        for (int i = 0; i < 16; i++) begin
            rnd = lfsr_take(8);
            vram_store(a, rnd[7:0]);
        end
        set_read_addr(12'h800);
        for (int i = 0; i < 16; i++) begin
            io_read(8'h98, rd_val);
            check_value(32'(vmem[12'h800 + i]), 32'(rd_val));
        end
        close_test();

        cur_test = "decode";
        set_write_addr(12'h800);
        io_access(8'h98, 1'b1, ~vmem[12'h800], 1'b1, rd_val);
        io_write(8'h9C, ~vmem[12'h800]);
        io_write(8'h18, ~vmem[12'h800]);
        io_read(8'h9C, rd_val);
        check_value(32'hFF, 32'(rd_val));
        set_read_addr(12'h800);
        io_read(8'h98, rd_val);
        check_value(32'(vmem[12'h800]), 32'(rd_val));
        close_test();

        cur_test = "display";
        load_palette();
        a = 12'h000;
        set_write_addr(a);
        for (int i = 0; i < 24 * 16; i++) begin
            rnd = lfsr_take(8);
            vram_store(a, rnd[7:0]);
        end
        rnd = lfsr_take(4);
        backdrop_m = rnd[3:0];
        write_reg(5'd7, {4'd0, backdrop_m});
        write_reg(5'd1, 8'h40);
        disp_on = 1'b1;
        wait_frame();
        disp_chk = 1'b1;
        wait_frame();
        disp_chk = 1'b0;
        write_reg(5'd1, 8'h00);
        disp_on = 1'b0;
        wait_frame();
        disp_chk = 1'b1;
        wait_frame();
        disp_chk = 1'b0;
        close_test();

        // Line and sync lengths are checked all along, this frame closes it
        cur_test = "timing";
        wait_frame();
        close_test();

        cur_test = "interrupt";
        io_read(8'h99, rd_val);
        write_reg(5'd1, 8'h20);
        wait_irq(t1);
        io_read(8'h99, rd_val);
        check_value(32'h80, 32'(rd_val));
        check_value(32'h0, 32'(interrupt));
        wait_irq(t2);
        check_value(FRAME_CYCLES, 32'((t2 - t1) / CLK_NS));
        write_reg(5'd1, 8'h00);
        io_read(8'h99, rd_val);
        irq_off = 1'b1;
        wait_frame();
        irq_off = 1'b0;
        close_test();

        $display("tests: %0d passed, %0d failed", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/vdp_top.sv
// VDP top level: CPU I/O ports in, aligned video timing and RGB out
`timescale 1ns/1ns
`default_nettype none

module vdp_top (
    input  logic            cpu_bus,
    input  logic            rst_n,
    input  logic            iorq,
    input  logic            m1,
    input  logic            req,
    input  logic            wr,
    input  vdp_pkg::byte_t  addr,
    input  vdp_pkg::byte_t  data_in,
    output vdp_pkg::byte_t  data_out,
    output logic            interrupt,
    output vdp_pkg::rgb8_t  r,
    output vdp_pkg::rgb8_t  g,
    output vdp_pkg::rgb8_t  b,
    output logic            hs,
    output logic            vs,
    output logic            de,
    output logic            hblank,
    output logic            vblank
);
    import vdp_pkg::*;

    vram_cpu_if cpu_vram ();

    hpos_t      hpos;
    vpos_t      vpos;
    vram_addr_t disp_addr;
    byte_t      disp_q, pal_data;
    color_idx_t backdrop, pal_idx, pix_idx;
    logic       active, fetch, hs_c, vs_c, hblank_c, vblank_c, frame_start;
    logic       disp_rd, pix_valid, display_en;
    logic       pal_we, pal_second, pal_idx_set;
    logic [4:0] sync_p [PIPE_DELAY];

    vdp_port_ctrl port_ctrl_i (
        .cpu_bus, .rst_n, .iorq, .m1, .req, .wr, .addr, .data_in, .data_out,
        .vram (cpu_vram.ctrl_mp),
        .frame_start, .interrupt, .display_en, .backdrop,
        .pal_we, .pal_data, .pal_second, .pal_idx_set, .pal_idx
    );

    vdp_vram vram_i (
        .cpu_bus, .rst_n, .vram (cpu_vram.mem_mp), .disp_rd, .disp_addr, .disp_q
    );

    vdp_scan_timing scan_timing_i (
        .cpu_bus, .rst_n, .hpos, .vpos, .active, .fetch,
        .hs (hs_c), .vs (vs_c), .hblank (hblank_c), .vblank (vblank_c), .frame_start
    );

    vdp_bitmap_fetch bitmap_fetch_i (
        .cpu_bus, .rst_n, .hpos, .vpos, .fetch, .active,
        .disp_rd, .disp_addr, .disp_q, .pix_idx, .pix_valid
    );

    vdp_palette palette_i (
        .cpu_bus, .rst_n, .pal_we, .pal_data, .pal_second, .pal_idx_set, .pal_idx,
        .pix_idx, .pix_valid, .display_en, .backdrop, .r, .g, .b
    );

    // Timing flags ride the same three stages as the pixel path
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PIPE_DELAY; i++)
                sync_p[i] <= '0;
        end else begin
            sync_p[0] <= {hs_c, vs_c, active, hblank_c, vblank_c};
            for (int i = 1; i < PIPE_DELAY; i++)
                sync_p[i] <= sync_p[i-1];
        end
    end

    assign {hs, vs, de, hblank, vblank} = sync_p[PIPE_DELAY-1];

endmodule

`default_nettype wire

// File: logic/vdp_palette.sv
// VDP palette: 16 entries of 9-bit RGB, written in byte pairs, expanded to 8 bits
`timescale 1ns/1ns
`default_nettype none

module vdp_palette (
    input  logic                 cpu_bus,
    input  logic                 rst_n,
    input  logic                 pal_we,
    input  vdp_pkg::byte_t       pal_data,
    input  logic                 pal_second,
    input  logic                 pal_idx_set,
    input  vdp_pkg::color_idx_t  pal_idx,
    input  vdp_pkg::color_idx_t  pix_idx,
    input  logic                 pix_valid,
    input  logic                 display_en,
    input  vdp_pkg::color_idx_t  backdrop,
    output vdp_pkg::rgb8_t       r,
    output vdp_pkg::rgb8_t       g,
    output vdp_pkg::rgb8_t       b
);
    import vdp_pkg::*;

    rgb3_t      pal_r [PAL_ENTRIES];
    rgb3_t      pal_g [PAL_ENTRIES];
    rgb3_t      pal_b [PAL_ENTRIES];
    rgb3_t      red_l;
    rgb3_t      blue_l;
    color_idx_t wr_idx;
    color_idx_t sel;

    // Repeat the 3-bit level so full scale maps to 0xFF
    function automatic rgb8_t expand(rgb3_t c);
        return {c, c, c[2:1]};
    endfunction

    // First byte carries red and blue
    always_ff @(posedge cpu_bus) begin
        if (pal_we && !pal_second) begin
            red_l  <= pal_data[6:4];
            blue_l <= pal_data[2:0];
        end
    end

    // Green completes the entry and the index moves on
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= '0;
            for (int i = 0; i < PAL_ENTRIES; i++) begin
                pal_r[i] <= '0;
                pal_g[i] <= '0;
                pal_b[i] <= '0;
            end
        end else if (pal_idx_set) begin
            wr_idx <= pal_idx;
        end else if (pal_we && pal_second) begin
            pal_r[wr_idx] <= red_l;
            pal_g[wr_idx] <= pal_data[2:0];
            pal_b[wr_idx] <= blue_l;
            wr_idx        <= wr_idx + 1'b1;
        end
    end

    // Backdrop fills the border and the whole screen while display is off
    assign sel = (pix_valid && display_en) ? pix_idx : backdrop;

    always_ff @(posedge cpu_bus) begin
        r <= expand(pal_r[sel]);
        g <= expand(pal_g[sel]);
        b <= expand(pal_b[sel]);
    end

endmodule

`default_nettype wire

// File: logic/vdp_bitmap_fetch.sv
// VDP bitmap fetch: display address from scan position, byte split into two pixels
`timescale 1ns/1ns
`default_nettype none

module vdp_bitmap_fetch (
    input  logic                 cpu_bus,
    input  logic                 rst_n,
    input  vdp_pkg::hpos_t       hpos,
    input  vdp_pkg::vpos_t       vpos,
    input  logic                 fetch,
    input  logic                 active,
    output logic                 disp_rd,
    output vdp_pkg::vram_addr_t  disp_addr,
    input  vdp_pkg::byte_t       disp_q,
    output vdp_pkg::color_idx_t  pix_idx,
    output logic                 pix_valid
);
    import vdp_pkg::*;

    byte_t held;
    logic  active_d;
    logic  odd_d;

    // Linear bitmap, two pixels per byte
    assign disp_rd   = fetch;
    assign disp_addr = vram_addr_t'(vpos) * BYTES_PER_LINE + vram_addr_t'(hpos[6:1]);

    // Stage 1 follows the VRAM read, stage 2 presents the pixel index
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            active_d  <= 1'b0;
            odd_d     <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            active_d  <= active;
            odd_d     <= hpos[0];
            pix_valid <= active_d;
        end
    end

    // High nibble goes straight through, the byte is kept for the odd pixel
    always_ff @(posedge cpu_bus) begin
        if (!odd_d)
            held <= disp_q;
        pix_idx <= odd_d ? held[3:0] : disp_q[7:4];
    end

endmodule

`default_nettype wire

// File: logic/vdp_scan_timing.sv
// VDP scan timing: position counters with sync, blank, active window and frame event
`timescale 1ns/1ns
`default_nettype none

module vdp_scan_timing (
    input  logic            cpu_bus,
    input  logic            rst_n,
    output vdp_pkg::hpos_t  hpos,
    output vdp_pkg::vpos_t  vpos,
    output logic            active,
    output logic            fetch,
    output logic            hs,
    output logic            vs,
    output logic            hblank,
    output logic            vblank,
    output logic            frame_start
);
    import vdp_pkg::*;

    // One pixel per clock, lines wrap at H_TOTAL and frames at V_TOTAL
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            hpos <= '0;
            vpos <= '0;
        end else if (hpos == H_TOTAL - 1'b1) begin
            hpos <= '0;
            vpos <= (vpos == V_TOTAL - 1'b1) ? '0 : vpos + 1'b1;
        end else begin
            hpos <= hpos + 1'b1;
        end
    end

    // Everything below is decoded at the counter stage, the top level
    // delays it to line up with RGB
    assign hblank = (hpos >= H_ACTIVE);
    assign vblank = (vpos >= V_ACTIVE);
    assign active = !hblank && !vblank;

    // Each fetched byte covers an even pixel and the odd one after it
    assign fetch = active && !hpos[0];

    assign hs = (hpos >= H_SYNC_START) && (hpos < H_SYNC_START + H_SYNC_LEN);
    assign vs = (vpos >= V_SYNC_START) && (vpos < V_SYNC_START + V_SYNC_LEN);

    // First cycle of the first blank line
    assign frame_start = (hpos == '0) && (vpos == V_ACTIVE);

    a_hpos_range: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        hpos < H_TOTAL);

endmodule

`default_nettype wire

// File: logic/vdp_vram.sv
// VDP video memory: display reads take priority, CPU requests fill the free slots
`timescale 1ns/1ns
`default_nettype none

module vdp_vram (
    input  logic                 cpu_bus,
    input  logic                 rst_n,
    vram_cpu_if.mem_mp           vram,
    input  logic                 disp_rd,
    input  vdp_pkg::vram_addr_t  disp_addr,
    output vdp_pkg::byte_t       disp_q
);
    import vdp_pkg::*;

    localparam int VRAM_BYTES = 1 << VRAM_ADDR_W;

    byte_t mem [VRAM_BYTES];
    logic  pending;

    // A request is seen one cycle after it rises, then waits for a slot
    // the display is not using
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n)
            pending <= 1'b0;
        else
            pending <= vram.req && !vram.ack;
    end

    // The CPU access happens in the ack cycle itself
    assign vram.ack   = pending && !disp_rd;
    assign vram.rdata = mem[vram.addr];

    // One port into the array per cycle
    always_ff @(posedge cpu_bus) begin
        if (disp_rd)
            disp_q <= mem[disp_addr];
        if (vram.ack && vram.we)
            mem[vram.addr] <= vram.wdata;
    end

    // Display reads fall on even pixels only, so a request never waits
    // more than two cycles for its slot
    a_cpu_latency: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        $rose(vram.req) |-> ##[1:2] vram.ack);

endmodule

`default_nettype wire

// File: logic/vdp_port_ctrl.sv
// VDP port controller: I/O decode, setup sequence, registers, VRAM access and status
`timescale 1ns/1ns
`default_nettype none

module vdp_port_ctrl (
    input  logic                 cpu_bus,
    input  logic                 rst_n,
    input  logic                 iorq,
    input  logic                 m1,
    input  logic                 req,
    input  logic                 wr,
    input  vdp_pkg::byte_t       addr,
    input  vdp_pkg::byte_t       data_in,
    output vdp_pkg::byte_t       data_out,
    vram_cpu_if.ctrl_mp          vram,
    input  logic                 frame_start,
    output logic                 interrupt,
    output logic                 display_en,
    output vdp_pkg::color_idx_t  backdrop,
    output logic                 pal_we,
    output vdp_pkg::byte_t       pal_data,
    output logic                 pal_second,
    output logic                 pal_idx_set,
    output vdp_pkg::color_idx_t  pal_idx
);
    import vdp_pkg::*;

    ctrl_state_t state;
    byte_t       first_byte;
    byte_t       rd_buf;
    byte_t       wr_buf;
    vram_addr_t  vaddr;
    logic        access, wr_data, rd_data, wr_ctrl, rd_ctrl, wr_pal;
    logic        setup_wr, reg_wr;
    logic        req_r, we_r, irq_en, pal_phase, frame_flag;

    // I/O cycle that is not an M1 fetch and falls in our four-port window
    assign access  = iorq && !m1 && req && (addr[7:2] == IO_BASE[7:2]);
    assign wr_data = access && wr && (addr[1:0] == PORT_DATA);
    assign rd_data = access && !wr && (addr[1:0] == PORT_DATA);
    assign wr_ctrl = access && wr && (addr[1:0] == PORT_CTRL);
    assign rd_ctrl = access && !wr && (addr[1:0] == PORT_CTRL);
    assign wr_pal  = access && wr && (addr[1:0] == PORT_PAL);

    // Second byte of the pair, bit 7 picks register write over address setup
    assign setup_wr = wr_ctrl && (state == CTRL_SECOND);
    assign reg_wr   = setup_wr && data_in[7];

    // Reads are answered in the same cycle; anything else floats the bus high
    always_comb begin
        data_out = 8'hFF;
        if (rd_data)
            data_out = rd_buf;
        else if (rd_ctrl)
            data_out = {frame_flag, 7'd0};
    end

    // Status read also realigns the two-byte sequence
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_IDLE;
        end else if (rd_ctrl) begin
            state <= CTRL_IDLE;
        end else if (wr_ctrl) begin
            state <= (state == CTRL_IDLE) ? CTRL_SECOND : CTRL_IDLE;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (wr_ctrl && state == CTRL_IDLE)
            first_byte <= data_in;
        if (wr_data)
            wr_buf <= data_in;
        // Prefetched byte lands in the read-ahead buffer
        if (vram.ack && !we_r)
            rd_buf <= vram.rdata;
    end

    // Only mode bits 6 and 5 and the backdrop nibble are kept
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            display_en <= 1'b0;
            irq_en     <= 1'b0;
            backdrop   <= '0;
        end else if (reg_wr) begin
            if (data_in[4:0] == REG_MODE) begin
                display_en <= first_byte[6];
                irq_en     <= first_byte[5];
            end
            if (data_in[4:0] == REG_BACKDROP)
                backdrop <= first_byte[3:0];
        end
    end

    // Address counter steps once per served request, read or write
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            vaddr <= '0;
            req_r <= 1'b0;
            we_r  <= 1'b0;
        end else begin
            if (vram.ack) begin
                req_r <= 1'b0;
                vaddr <= vaddr + 1'b1;
            end
            if (wr_data) begin
                req_r <= 1'b1;
                we_r  <= 1'b1;
            end else if (rd_data) begin
                // Data port read hands out the buffer and refills it
                req_r <= 1'b1;
                we_r  <= 1'b0;
            end else if (setup_wr && !data_in[7]) begin
                vaddr <= {data_in[3:0], first_byte};
                // Read mode starts filling the buffer straight away
                if (!data_in[6]) begin
                    req_r <= 1'b1;
                    we_r  <= 1'b0;
                end
            end
        end
    end

    assign vram.req   = req_r;
    assign vram.we    = we_r;
    assign vram.addr  = vaddr;
    assign vram.wdata = wr_buf;

    // Palette byte pairing restarts whenever the index is reloaded
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n)
            pal_phase <= 1'b0;
        else if (pal_idx_set)
            pal_phase <= 1'b0;
        else if (wr_pal)
            pal_phase <= !pal_phase;
    end

    assign pal_we      = wr_pal;
    assign pal_data    = data_in;
    assign pal_second  = pal_phase;
    assign pal_idx_set = reg_wr && (data_in[4:0] == REG_PAL_IDX);
    assign pal_idx     = first_byte[3:0];

    // A vblank start in the same cycle as a status read wins
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            frame_flag <= 1'b0;
            interrupt  <= 1'b0;
        end else begin
            if (rd_ctrl)
                frame_flag <= 1'b0;
            if (frame_start)
                frame_flag <= 1'b1;
            interrupt <= frame_flag && irq_en;
        end
    end

    // The arbiter must see a steady request until it answers
    a_req_held: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        vram.req && !vram.ack |=> vram.req && $stable(vram.addr));

    // Ack only ever answers an outstanding request
    a_ack_has_req: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        vram.ack |-> vram.req);

endmodule

`default_nettype wire

// File: logic/vram_cpu_if.sv
// CPU VRAM request channel between the port controller and the VRAM arbiter
`timescale 1ns/1ns
`default_nettype none

interface vram_cpu_if;
    import vdp_pkg::*;

    // Request side holds all four until ack
    logic       req;
    logic       we;
    vram_addr_t addr;
    byte_t      wdata;

    // Ack is a single-cycle pulse, rdata is valid with it
    logic       ack;
    byte_t      rdata;

    modport ctrl_mp (output req, we, addr, wdata, input ack, rdata);
    modport mem_mp (input req, we, addr, wdata, output ack, rdata);

endinterface

`default_nettype wire

// File: logic/vdp_pkg.sv
// VDP package: bus widths, typedefs, port map, frame geometry and control FSM states
`default_nettype none

package vdp_pkg;

    // Widths that carry a meaning on the bus and in the datapath
    localparam int VRAM_ADDR_W = 12;

    typedef logic [7:0]             byte_t;
    typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;
    typedef logic [3:0]             color_idx_t;
    typedef logic [2:0]             rgb3_t;
    typedef logic [7:0]             rgb8_t;
    typedef logic [6:0]             hpos_t;
    typedef logic [5:0]             vpos_t;

    // I/O map, the block answers on four ports from the base upward
    localparam byte_t      IO_BASE   = 8'h98;
    localparam logic [1:0] PORT_DATA = 2'd0;
    localparam logic [1:0] PORT_CTRL = 2'd1;
    localparam logic [1:0] PORT_PAL  = 2'd2;

    // Small frame, sized to keep simulation short
    localparam hpos_t H_ACTIVE     = 7'd32;
    localparam hpos_t H_TOTAL      = 7'd64;
    localparam hpos_t H_SYNC_START = 7'd40;
    localparam hpos_t H_SYNC_LEN   = 7'd6;
    localparam vpos_t V_ACTIVE     = 6'd24;
    localparam vpos_t V_TOTAL      = 6'd40;
    localparam vpos_t V_SYNC_START = 6'd28;
    localparam vpos_t V_SYNC_LEN   = 6'd2;

    // Two pixels per byte in the bitmap
    localparam vram_addr_t BYTES_PER_LINE = 12'd16;
    localparam int         PAL_ENTRIES    = 16;

    // Register numbers as carried in bits 4..0 of the second setup byte
    localparam logic [4:0] REG_MODE     = 5'd1;
    localparam logic [4:0] REG_BACKDROP = 5'd7;
    localparam logic [4:0] REG_PAL_IDX  = 5'd16;

    // Counter stage to RGB outputs
    localparam int PIPE_DELAY = 3;

    typedef enum logic {CTRL_IDLE, CTRL_SECOND} ctrl_state_t;

endpackage

`default_nettype wire
